// File: Makefile
# Verilator simulation of the AXI NoC chimney

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_axi_noc_chimney
FILELIST  := project.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: axi_cfg_pkg.sv
// AXI4 configuration package
// Address, ID, data and burst length widths
// Channel structs for AW/AR, W, B and R beats

`default_nettype none

package axi_cfg_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned LenWidth  = 8;

  // AW and AR share one layout
  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [AddrWidth-1:0] addr;
    logic [LenWidth-1:0]  len;
  } axi_ax_chan_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic                 last;
  } axi_w_chan_t;

  typedef struct packed {
    logic [IdWidth-1:0] id;
    logic [1:0]         resp;
  } axi_b_chan_t;

  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [DataWidth-1:0] data;
    logic [1:0]           resp;
    logic                 last;
  } axi_r_chan_t;

endpackage

`default_nettype wire

// File: axi_noc_chimney.sv
// AXI4 manager-side network interface
// SAM decoders for AW and AR, request packer and link arbiter
// Response unpacker towards AXI B and R

`default_nettype none
`timescale 1ns/10ps

module axi_noc_chimney
  import axi_cfg_pkg::*;
  import floo_noc_pkg::*;
(
  input  logic           clk_i,
  input  logic           reset_i,
  input  node_id_t       id_i,
  // AXI manager port
  input  axi_ax_chan_t   axi_aw_i,
  input  logic           axi_aw_valid_i,
  output logic           axi_aw_ready_o,
  input  axi_w_chan_t    axi_w_i,
  input  logic           axi_w_valid_i,
  output logic           axi_w_ready_o,
  input  axi_ax_chan_t   axi_ar_i,
  input  logic           axi_ar_valid_i,
  output logic           axi_ar_ready_o,
  output axi_b_chan_t    axi_b_o,
  output logic           axi_b_valid_o,
  input  logic           axi_b_ready_i,
  output axi_r_chan_t    axi_r_o,
  output logic           axi_r_valid_o,
  input  logic           axi_r_ready_i,
  // Request link out
  output floo_req_flit_t floo_req_o,
  output logic           floo_req_valid_o,
  input  logic           floo_req_ready_i,
  // Response link in
  input  floo_rsp_flit_t floo_rsp_i,
  input  logic           floo_rsp_valid_i,
  output logic           floo_rsp_ready_o
);

  // Index 0 is AW, index 1 is AR
  logic [1:0][AddrWidth-1:0] dec_addr;
  node_id_t [1:0]            dec_dst;
  floo_req_flit_t [1:0]      lane_flit;
  logic [1:0]                lane_valid;
  logic [1:0]                lane_grant;

  assign dec_addr[0] = axi_aw_i.addr;
  assign dec_addr[1] = axi_ar_i.addr;

  for (genvar i = 0; i < 2; i++) begin : gen_sam_dec
    sam_route_decoder i_sam_dec (
      .addr_i   ( dec_addr[i] ),
      .dst_id_o ( dec_dst[i]  )
    );
  end

  req_flit_packer i_packer (
    .clk_i        ( clk_i          ),
    .reset_i      ( reset_i        ),
    .aw_i         ( axi_aw_i       ),
    .aw_valid_i   ( axi_aw_valid_i ),
    .aw_ready_o   ( axi_aw_ready_o ),
    .w_i          ( axi_w_i        ),
    .w_valid_i    ( axi_w_valid_i  ),
    .w_ready_o    ( axi_w_ready_o  ),
    .ar_i         ( axi_ar_i       ),
    .ar_valid_i   ( axi_ar_valid_i ),
    .ar_ready_o   ( axi_ar_ready_o ),
    .aw_dst_i     ( dec_dst[0]     ),
    .ar_dst_i     ( dec_dst[1]     ),
    .id_i         ( id_i           ),
    .lane_flit_o  ( lane_flit      ),
    .lane_valid_o ( lane_valid     ),
    .lane_grant_i ( lane_grant     )
  );

  wormhole_arbiter i_req_arb (
    .clk_i   ( clk_i            ),
    .reset_i ( reset_i          ),
    .flit_i  ( lane_flit        ),
    .valid_i ( lane_valid       ),
    .grant_o ( lane_grant       ),
    .flit_o  ( floo_req_o       ),
    .valid_o ( floo_req_valid_o ),
    .ready_i ( floo_req_ready_i )
  );

  rsp_flit_unpacker i_unpacker (
    .flit_i    ( floo_rsp_i       ),
    .valid_i   ( floo_rsp_valid_i ),
    .ready_o   ( floo_rsp_ready_o ),
    .b_o       ( axi_b_o          ),
    .b_valid_o ( axi_b_valid_o    ),
    .b_ready_i ( axi_b_ready_i    ),
    .r_o       ( axi_r_o          ),
    .r_valid_o ( axi_r_valid_o    ),
    .r_ready_i ( axi_r_ready_i    )
  );

endmodule

`default_nettype wire

// File: chimney_assertions.sv
// Concurrent checks on the chimney handshakes
// Request link quiet in reset, valids held under back-pressure

`default_nettype none
`timescale 1ns/10ps

module chimney_assertions
  import axi_cfg_pkg::*;
  import floo_noc_pkg::*;
(
  input logic           clk_i,
  input logic           reset_i,
  input axi_ax_chan_t   axi_aw_i,
  input logic           axi_aw_valid_i,
  input logic           axi_aw_ready_o,
  input axi_w_chan_t    axi_w_i,
  input logic           axi_w_valid_i,
  input logic           axi_w_ready_o,
  input axi_ax_chan_t   axi_ar_i,
  input logic           axi_ar_valid_i,
  input logic           axi_ar_ready_o,
  input axi_b_chan_t    axi_b_o,
  input logic           axi_b_valid_o,
  input logic           axi_b_ready_i,
  input axi_r_chan_t    axi_r_o,
  input logic           axi_r_valid_o,
  input logic           axi_r_ready_i,
  input floo_req_flit_t floo_req_o,
  input logic           floo_req_valid_o,
  input logic           floo_req_ready_i,
  input floo_rsp_flit_t floo_rsp_i,
  input logic           floo_rsp_valid_i,
  input logic           floo_rsp_ready_o
);

  a_req_reset: assert property (@(posedge clk_i) reset_i |-> !floo_req_valid_o)
    else $error("request link valid during reset");

  // A stalled link flit stays on the link until it is taken
  a_req_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    floo_req_valid_o && !floo_req_ready_i |=> floo_req_valid_o && $stable(floo_req_o))
    else $error("request link flit changed while stalled");

  a_aw_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    axi_aw_valid_i && !axi_aw_ready_o |=> axi_aw_valid_i && $stable(axi_aw_i))
    else $error("AW beat changed while stalled");

  a_w_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    axi_w_valid_i && !axi_w_ready_o |=> axi_w_valid_i && $stable(axi_w_i))
    else $error("W beat changed while stalled");

  a_ar_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    axi_ar_valid_i && !axi_ar_ready_o |=> axi_ar_valid_i && $stable(axi_ar_i))
    else $error("AR beat changed while stalled");

  a_b_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    axi_b_valid_o && !axi_b_ready_i |=> axi_b_valid_o && $stable(axi_b_o))
    else $error("B beat changed while stalled");

  a_r_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    axi_r_valid_o && !axi_r_ready_i |=> axi_r_valid_o && $stable(axi_r_o))
    else $error("R beat changed while stalled");

  a_rsp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    floo_rsp_valid_i && !floo_rsp_ready_o |=> floo_rsp_valid_i && $stable(floo_rsp_i))
    else $error("response flit changed while stalled");

endmodule

bind axi_noc_chimney chimney_assertions i_chimney_assertions (.*);

`default_nettype wire

// File: floo_noc_pkg.sv
// NoC link package
// Node IDs, channel codes and the system address map
// Flit header, payload unions and request/response flits

`default_nettype none

package floo_noc_pkg;

  import axi_cfg_pkg::*;

  localparam int unsigned NodeIdWidth = 4;
  localparam int unsigned NumSamRules = 4;

  typedef logic [NodeIdWidth-1:0] node_id_t;

  typedef enum logic [2:0] {
    AxiAw = 3'd0,
    AxiW  = 3'd1,
    AxiAr = 3'd2,
    AxiB  = 3'd3,
    AxiR  = 3'd4
  } axi_ch_e;

  ////////////////////////////////////////////////////////////
  // System address map

  // End address is exclusive
  typedef struct packed {
    logic [AddrWidth-1:0] start_addr;
    logic [AddrWidth-1:0] end_addr;
    node_id_t             id;
  } sam_rule_t;

  // Highest rule index first
  localparam sam_rule_t [NumSamRules-1:0] Sam = {
    sam_rule_t'{start_addr: 32'h4000_0000, end_addr: 32'h5000_0000, id: 4'd4},
    sam_rule_t'{start_addr: 32'h3000_0000, end_addr: 32'h4000_0000, id: 4'd3},
    sam_rule_t'{start_addr: 32'h2000_0000, end_addr: 32'h3000_0000, id: 4'd2},
    sam_rule_t'{start_addr: 32'h1000_0000, end_addr: 32'h2000_0000, id: 4'd1}
  };

  localparam node_id_t SamDefaultNode = node_id_t'(0);

  ////////////////////////////////////////////////////////////
  // Flits

  typedef struct packed {
    node_id_t dst_id;
    node_id_t src_id;
    axi_ch_e  axi_ch;
    logic     last;
  } flit_hdr_t;

  localparam int unsigned ReqPadWidth = $bits(axi_ax_chan_t) - $bits(axi_w_chan_t);
  localparam int unsigned RspPadWidth = $bits(axi_r_chan_t) - $bits(axi_b_chan_t);

  typedef struct packed {
    logic [ReqPadWidth-1:0] rsvd;
    axi_w_chan_t            beat;
  } req_w_pad_t;

  typedef struct packed {
    logic [RspPadWidth-1:0] rsvd;
    axi_b_chan_t            beat;
  } rsp_b_pad_t;

  // Same bits read as an address beat or a padded W beat
  typedef union packed {
    axi_ax_chan_t ax;
    req_w_pad_t   w;
  } req_payload_u;

  typedef union packed {
    rsp_b_pad_t  b;
    axi_r_chan_t r;
  } rsp_payload_u;

  typedef struct packed {
    flit_hdr_t    hdr;
    req_payload_u payload;
  } floo_req_flit_t;

  typedef struct packed {
    flit_hdr_t    hdr;
    rsp_payload_u payload;
  } floo_rsp_flit_t;

endpackage

`default_nettype wire

// File: project.f
axi_cfg_pkg.sv
floo_noc_pkg.sv
sam_route_decoder.sv
req_flit_packer.sv
wormhole_arbiter.sv
rsp_flit_unpacker.sv
axi_noc_chimney.sv
chimney_assertions.sv
tb_axi_noc_chimney.sv

// File: req_flit_packer.sv
// Request flit packer
// AW/W sequencing on lane 0, AR on lane 1
// Holds the W destination of the open write burst

`default_nettype none
`timescale 1ns/10ps

module req_flit_packer
  import axi_cfg_pkg::*;
  import floo_noc_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,
  // AXI request channels
  input  axi_ax_chan_t         aw_i,
  input  logic                 aw_valid_i,
  output logic                 aw_ready_o,
  input  axi_w_chan_t          w_i,
  input  logic                 w_valid_i,
  output logic                 w_ready_o,
  input  axi_ax_chan_t         ar_i,
  input  logic                 ar_valid_i,
  output logic                 ar_ready_o,
  // Decoded destinations and own node ID
  input  node_id_t             aw_dst_i,
  input  node_id_t             ar_dst_i,
  input  node_id_t             id_i,
  // Lanes towards the arbiter
  output floo_req_flit_t [1:0] lane_flit_o,
  output logic [1:0]           lane_valid_o,
  input  logic [1:0]           lane_grant_i
);

  typedef enum logic {SelAw, SelW} aw_w_sel_e;

  aw_w_sel_e      sel_q;
  aw_w_sel_e      sel_d;
  node_id_t       w_dst_q;
  logic           aw_fire;
  logic           w_fire;
  floo_req_flit_t aw_flit;
  floo_req_flit_t w_flit;
  floo_req_flit_t ar_flit;

  ////////////////////////////////////////////////////////////
  // Flit packing

  always_comb begin
    aw_flit            = '0;
    aw_flit.hdr.dst_id = aw_dst_i;
    aw_flit.hdr.src_id = id_i;
    aw_flit.hdr.axi_ch = AxiAw;
    // W beats follow, keep the link open
    aw_flit.hdr.last   = 1'b0;
    aw_flit.payload.ax = aw_i;
  end

  always_comb begin
    w_flit                   = '0;
    w_flit.hdr.dst_id        = w_dst_q;
    w_flit.hdr.src_id        = id_i;
    w_flit.hdr.axi_ch        = AxiW;
    w_flit.hdr.last          = w_i.last;
    w_flit.payload.w.rsvd    = '0;
    w_flit.payload.w.beat    = w_i;
  end

  always_comb begin
    ar_flit            = '0;
    ar_flit.hdr.dst_id = ar_dst_i;
    ar_flit.hdr.src_id = id_i;
    ar_flit.hdr.axi_ch = AxiAr;
    ar_flit.hdr.last   = 1'b1;
    ar_flit.payload.ax = ar_i;
  end

  ////////////////////////////////////////////////////////////
  // Lane muxing and handshakes

  assign lane_flit_o[0]  = (sel_q == SelAw) ? aw_flit : w_flit;
  assign lane_flit_o[1]  = ar_flit;
  assign lane_valid_o[0] = (sel_q == SelAw) ? aw_valid_i : w_valid_i;
  assign lane_valid_o[1] = ar_valid_i;

  assign aw_ready_o = lane_grant_i[0] && (sel_q == SelAw);
  assign w_ready_o  = lane_grant_i[0] && (sel_q == SelW);
  assign ar_ready_o = lane_grant_i[1];

  assign aw_fire = aw_valid_i && aw_ready_o;
  assign w_fire  = w_valid_i && w_ready_o;

  // Stay on W until the last beat of the burst goes out
  always_comb begin
    sel_d = sel_q;
    if (aw_fire) begin
      sel_d = SelW;
    end
    if (w_fire && w_i.last) begin
      sel_d = SelAw;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sel_q <= SelAw;
    end else begin
      sel_q <= sel_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      w_dst_q <= aw_dst_i;
    end
  end

endmodule

`default_nettype wire

// File: rsp_flit_unpacker.sv
// Response flit unpacker
// Steers response flits to AXI B or R by channel code
// Other channel codes are accepted and dropped

`default_nettype none
`timescale 1ns/10ps

module rsp_flit_unpacker
  import axi_cfg_pkg::*;
  import floo_noc_pkg::*;
(
  // Response link
  input  floo_rsp_flit_t flit_i,
  input  logic           valid_i,
  output logic           ready_o,
  // AXI B channel
  output axi_b_chan_t    b_o,
  output logic           b_valid_o,
  input  logic           b_ready_i,
  // AXI R channel
  output axi_r_chan_t    r_o,
  output logic           r_valid_o,
  input  logic           r_ready_i
);

  logic is_b;
  logic is_r;

  assign is_b = (flit_i.hdr.axi_ch == AxiB);
  assign is_r = (flit_i.hdr.axi_ch == AxiR);

  // Same payload bits, two views
  assign b_o = flit_i.payload.b.beat;
  assign r_o = flit_i.payload.r;

  assign b_valid_o = valid_i && is_b;
  assign r_valid_o = valid_i && is_r;

  always_comb begin
    case (flit_i.hdr.axi_ch)
      AxiB:    ready_o = b_ready_i;
      AxiR:    ready_o = r_ready_i;
      // Stray request codes are sunk here
      default: ready_o = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// File: sam_route_decoder.sv
// SAM route decoder
// Maps an AXI address to a destination node ID
// Lowest matching rule wins, default node on a miss

`default_nettype none
`timescale 1ns/10ps

module sam_route_decoder
  import axi_cfg_pkg::*;
  import floo_noc_pkg::*;
(
  input  logic [AddrWidth-1:0] addr_i,
  output node_id_t             dst_id_o
);

  logic [NumSamRules-1:0] rule_hit;

  // One compare per rule, end address exclusive
  always_comb begin
    for (int i = 0; i < NumSamRules; i++) begin
      rule_hit[i] = (addr_i >= Sam[i].start_addr) && (addr_i < Sam[i].end_addr);
    end
  end

  // Priority select
  // Walk from the top so the lowest hit is written last
  always_comb begin
    dst_id_o = SamDefaultNode;
    for (int i = NumSamRules - 1; i >= 0; i--) begin
      if (rule_hit[i]) begin
        dst_id_o = Sam[i].id;
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_axi_noc_chimney.sv
// Testbench for the AXI NoC chimney
// Random AXI requests, response flits and link stalls from a Galois LFSR
// Reference model with per-lane expected queues and a comparing monitor

`default_nettype none
`timescale 1ns/10ps

module tb_axi_noc_chimney
  import axi_cfg_pkg::*;
  import floo_noc_pkg::*;
;

  localparam node_id_t NodeId    = 4'd9;
  localparam int       WaitLimit = 200;
  localparam int       NumWrites = 40;
  localparam int       NumReads  = 40;
  localparam int       NumRsps   = 60;

  logic           clk_i;
  logic           reset_i;
  axi_ax_chan_t   axi_aw_i;
  logic           axi_aw_valid_i;
  logic           axi_aw_ready_o;
  axi_w_chan_t    axi_w_i;
  logic           axi_w_valid_i;
  logic           axi_w_ready_o;
  axi_ax_chan_t   axi_ar_i;
  logic           axi_ar_valid_i;
  logic           axi_ar_ready_o;
  axi_b_chan_t    axi_b_o;
  logic           axi_b_valid_o;
  logic           axi_b_ready_i;
  axi_r_chan_t    axi_r_o;
  logic           axi_r_valid_o;
  logic           axi_r_ready_i;
  floo_req_flit_t floo_req_o;
  logic           floo_req_valid_o;
  logic           floo_req_ready_i;
  floo_rsp_flit_t floo_rsp_i;
  logic           floo_rsp_valid_i;
  logic           floo_rsp_ready_o;

  logic [31:0]    lfsr_state = 32'h5eb;
  logic           in_write_burst = 1'b0;
  int             req_checked = 0;
  int             rsp_checked = 0;

  // Lane 0 holds AW and W flits, lane 1 holds AR flits
  floo_req_flit_t exp_lane0[$];
  floo_req_flit_t exp_lane1[$];
  axi_b_chan_t    exp_b[$];
  axi_r_chan_t    exp_r[$];

  axi_noc_chimney uut (
    .clk_i, .reset_i, .id_i(NodeId),
    .axi_aw_i, .axi_aw_valid_i, .axi_aw_ready_o,
    .axi_w_i, .axi_w_valid_i, .axi_w_ready_o,
    .axi_ar_i, .axi_ar_valid_i, .axi_ar_ready_o,
    .axi_b_o, .axi_b_valid_o, .axi_b_ready_i,
    .axi_r_o, .axi_r_valid_o, .axi_r_ready_i,
    .floo_req_o, .floo_req_valid_o, .floo_req_ready_i,
    .floo_rsp_i, .floo_rsp_valid_i, .floo_rsp_ready_o
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Random source and reference model

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic axi_ax_chan_t random_ax();
    axi_ax_chan_t ax;
    ax.id   = IdWidth'(rand_bits(IdWidth));
    // Top nibble 0 to 7, so about half the addresses miss the map
    ax.addr = rand_bits(31);
    ax.len  = LenWidth'(rand_bits(2));
    return ax;
  endfunction

  // Rule k spans (k+1) * 0x1000_0000 up to the next multiple, node k+1
  function automatic node_id_t sam_node(input logic [31:0] addr);
    if (addr >= 32'h1000_0000 && addr < 32'h5000_0000) begin
      return node_id_t'(addr[31:28]);
    end
    return '0;
  endfunction

  // For a W flit, ax is the AW beat that opened the burst
  function automatic floo_req_flit_t expect_req_flit(input axi_ch_e ch, input axi_ax_chan_t ax,
                                                     input axi_w_chan_t w);
    floo_req_flit_t f;
    f            = '0;
    f.hdr.dst_id = sam_node(ax.addr);
    f.hdr.src_id = NodeId;
    f.hdr.axi_ch = ch;
    case (ch)
      AxiAw: begin
        f.hdr.last = 1'b0;
        f.payload.ax = ax;
      end
      AxiW: begin
        f.hdr.last = w.last;
        f.payload.ax = {11'd0, w};
      end
      default: begin
        f.hdr.last = 1'b1;
        f.payload.ax = ax;
      end
    endcase
    return f;
  endfunction

  ////////////////////////////////////////////////////////////
  // Error handling and waits

  task automatic report_error(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timed out after %0d cycles waiting for %s", WaitLimit, what);
    $display("Finished with errors");
    $fatal(1);
  endtask

  // Returns 2 ns after the edge where the beat was taken
  task automatic wait_accept(input int chan, input string what);
    int   cyc;
    logic hit;
    hit = 1'b0;
    for (cyc = 0; cyc < WaitLimit && !hit; cyc++) begin
      @(posedge clk_i);
      case (chan)
        0:       hit = axi_aw_ready_o;
        1:       hit = axi_w_ready_o;
        2:       hit = axi_ar_ready_o;
        default: hit = floo_rsp_ready_o;
      endcase
    end
    if (!hit) begin
      stop_on_timeout(what);
    end
    #2;
  endtask

  task automatic idle_gap();
    int n;
    n = int'(rand_bits(2)) % 3;
    repeat (n) begin
      @(posedge clk_i);
      #2;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus

  task automatic write_bursts(input int n);
    axi_ax_chan_t aw;
    axi_w_chan_t  w;
    for (int i = 0; i < n; i++) begin
      aw = random_ax();
      exp_lane0.push_back(expect_req_flit(AxiAw, aw, '0));
      axi_aw_i       = aw;
      axi_aw_valid_i = 1'b1;
      wait_accept(0, "the AW handshake");
      axi_aw_valid_i = 1'b0;
      for (int k = 0; k <= int'(aw.len); k++) begin
        w.data = rand_bits(32);
        w.last = (k == int'(aw.len));
        exp_lane0.push_back(expect_req_flit(AxiW, aw, w));
        axi_w_i       = w;
        axi_w_valid_i = 1'b1;
        wait_accept(1, "the W handshake");
        axi_w_valid_i = 1'b0;
        idle_gap();
      end
    end
  endtask

  task automatic read_beats(input int n);
    axi_ax_chan_t ar;
    for (int i = 0; i < n; i++) begin
      ar = random_ax();
      exp_lane1.push_back(expect_req_flit(AxiAr, ar, '0));
      axi_ar_i       = ar;
      axi_ar_valid_i = 1'b1;
      wait_accept(2, "the AR handshake");
      axi_ar_valid_i = 1'b0;
      idle_gap();
    end
  endtask

  task automatic response_flits(input int n);
    floo_rsp_flit_t f;
    axi_b_chan_t    b;
    axi_r_chan_t    r;
    logic [1:0]     kind;
    for (int i = 0; i < n; i++) begin
      kind         = 2'(rand_bits(2));
      f            = '0;
      f.hdr.dst_id = NodeId;
      f.hdr.src_id = node_id_t'(rand_bits(NodeIdWidth));
      f.hdr.last   = 1'b1;
      r.id         = IdWidth'(rand_bits(IdWidth));
      r.data       = rand_bits(32);
      r.resp       = 2'(rand_bits(2));
      r.last       = 1'(rand_bits(1));
      b.id         = r.id;
      b.resp       = r.resp;
      if (kind == 2'd0) begin
        // Request code on the response link, dropped by the chimney
        f.hdr.axi_ch = AxiAw;
        f.payload.r  = r;
      end else if (kind == 2'd1) begin
        f.hdr.axi_ch          = AxiB;
        f.payload.b.rsvd      = '0;
        f.payload.b.beat      = b;
        exp_b.push_back(b);
      end else begin
        f.hdr.axi_ch = AxiR;
        f.payload.r  = r;
        exp_r.push_back(r);
      end
      floo_rsp_i       = f;
      floo_rsp_valid_i = 1'b1;
      wait_accept(3, "the response link handshake");
      floo_rsp_valid_i = 1'b0;
      idle_gap();
    end
  endtask

  // Random stalls on the link and on B/R
  initial begin
    floo_req_ready_i = 1'b0;
    axi_b_ready_i    = 1'b0;
    axi_r_ready_i    = 1'b0;
    forever begin
      @(posedge clk_i);
      #2;
      floo_req_ready_i = |rand_bits(2);
      axi_b_ready_i    = |rand_bits(2);
      axi_r_ready_i    = |rand_bits(2);
    end
  end

  ////////////////////////////////////////////////////////////
  // Monitor

  always @(posedge clk_i) begin : compare_proc
    floo_req_flit_t got;
    floo_req_flit_t want;
    axi_b_chan_t    want_b;
    axi_r_chan_t    want_r;
    logic           axi_fire;
    if (!reset_i) begin
      assert (floo_req_ready_i || !(axi_aw_ready_o || axi_w_ready_o || axi_ar_ready_o))
        else report_error("AXI ready high while the link ready is low");
      axi_fire = (axi_aw_valid_i && axi_aw_ready_o) || (axi_w_valid_i && axi_w_ready_o)
                 || (axi_ar_valid_i && axi_ar_ready_o);
      assert (axi_fire == (floo_req_valid_o && floo_req_ready_i))
        else report_error("AXI beat and link flit not accepted in the same cycle");
      if (floo_req_valid_o && floo_req_ready_i) begin
        got = floo_req_o;
        if (got.hdr.axi_ch == AxiAr) begin
          assert (!in_write_burst) else report_error("AR flit inside a write burst");
          assert (exp_lane1.size() > 0) else report_error("unexpected AR flit");
          want = exp_lane1.pop_front();
        end else begin
          assert (exp_lane0.size() > 0) else report_error("unexpected write flit");
          want = exp_lane0.pop_front();
          if (got.hdr.axi_ch == AxiAw) begin
            in_write_burst = 1'b1;
          end else if (got.hdr.last) begin
            in_write_burst = 1'b0;
          end
        end
        assert (got == want)
          else report_error($sformatf("request flit %h, expected %h", got, want));
        req_checked++;
      end
      if (floo_rsp_valid_i) begin
        case (floo_rsp_i.hdr.axi_ch)
          AxiB: assert (axi_b_valid_o && !axi_r_valid_o && floo_rsp_ready_o == axi_b_ready_i)
            else report_error("B flit not steered to the B port");
          AxiR: assert (axi_r_valid_o && !axi_b_valid_o && floo_rsp_ready_o == axi_r_ready_i)
            else report_error("R flit not steered to the R port");
          default: assert (!axi_b_valid_o && !axi_r_valid_o && floo_rsp_ready_o)
            else report_error("stray response flit not dropped");
        endcase
      end
      if (axi_b_valid_o && axi_b_ready_i) begin
        assert (exp_b.size() > 0) else report_error("unexpected B beat");
        want_b = exp_b.pop_front();
        assert (axi_b_o == want_b)
          else report_error($sformatf("B beat %h, expected %h", axi_b_o, want_b));
        rsp_checked++;
      end
      if (axi_r_valid_o && axi_r_ready_i) begin
        assert (exp_r.size() > 0) else report_error("unexpected R beat");
        want_r = exp_r.pop_front();
        assert (axi_r_o == want_r)
          else report_error($sformatf("R beat %h, expected %h", axi_r_o, want_r));
        rsp_checked++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Main sequence

  initial begin : main_proc
    int cyc;
    reset_i          = 1'b1;
    axi_aw_i         = '0;
    axi_aw_valid_i   = 1'b0;
    axi_w_i          = '0;
    axi_w_valid_i    = 1'b0;
    axi_ar_i         = '0;
    axi_ar_valid_i   = 1'b0;
    floo_rsp_i       = '0;
    floo_rsp_valid_i = 1'b0;
    repeat (8) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    fork
      write_bursts(NumWrites);
      read_beats(NumReads);
      response_flits(NumRsps);
    join
    for (cyc = 0; cyc < WaitLimit; cyc++) begin
      if (exp_lane0.size() + exp_lane1.size() + exp_b.size() + exp_r.size() == 0) begin
        break;
      end
      @(posedge clk_i);
    end
    if (cyc == WaitLimit) begin
      stop_on_timeout("the expected queues to drain");
    end else begin
      $display("Checked %0d request flits and %0d response beats", req_checked, rsp_checked);
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: wormhole_arbiter.sv
// Wormhole arbiter for the request link
// Two lanes, round robin between bursts
// A lane keeps the link until its last flit is accepted

`default_nettype none
`timescale 1ns/10ps

module wormhole_arbiter
  import floo_noc_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  floo_req_flit_t [1:0] flit_i,
  input  logic [1:0]           valid_i,
  output logic [1:0]           grant_o,
  output floo_req_flit_t       flit_o,
  output logic                 valid_o,
  input  logic                 ready_i
);

  // prio_q is the favoured lane, or the owner while lock_q is set
  logic lock_q;
  logic prio_q;
  logic sel;
  logic accept;

  // Switch to the other lane only when unlocked and the favoured lane idles
  always_comb begin
    sel = prio_q;
    if (!lock_q && !valid_i[prio_q] && valid_i[~prio_q]) begin
      sel = ~prio_q;
    end
  end

  assign flit_o  = flit_i[sel];
  assign valid_o = valid_i[sel];
  assign accept  = valid_o && ready_i;

  always_comb begin
    grant_o      = '0;
    grant_o[sel] = ready_i;
  end

  ////////////////////////////////////////////////////////////
  // Lock and round-robin state

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_q <= 1'b0;
      prio_q <= 1'b0;
    end else if (accept) begin
      if (flit_o.hdr.last) begin
        // Burst done, hand priority to the other lane
        lock_q <= 1'b0;
        prio_q <= ~sel;
      end else begin
        lock_q <= 1'b1;
        prio_q <= sel;
      end
    end else if (valid_o) begin
      // Offered flit waits on the link, keep it on the output
      lock_q <= 1'b1;
      prio_q <= sel;
    end
  end

endmodule

`default_nettype wire
